/* prefetch_cfg.svh */
`ifndef PREFETCH_CFG_SVH
`define PREFETCH_CFG_SVH

//////////////////////////////////////////////////
// Fetch front end sizing
//////////////////////////////////////////////////

// Address and data width of the instruction bus
`define PF_XLEN 32

// Budget for requests in flight plus words held in the buffer
// Any value from 2 to 8 works
`define PF_DEPTH 4

// Wide enough for 0 up to PF_DEPTH
`define PF_CNT_W 4

`endif

/* prefetch_pkg.sv */
`include "prefetch_cfg.svh"

package prefetch_pkg;

  // Prefetcher address FSM
  // IDLE issues the sequential address or a fresh branch target
  // BRANCH_WAIT keeps offering a target the bus has not taken yet
  typedef enum logic [0:0] {
    IDLE,
    BRANCH_WAIT
  } prefetch_state_e;

  // Branch pulse from the core with its word aligned target
  typedef struct packed {
    logic                taken;
    logic [`PF_XLEN-1:0] addr;
  } branch_t;

  // Request towards the instruction bus
  typedef struct packed {
    logic                valid;
    logic [`PF_XLEN-1:0] addr;
  } bus_req_t;

  // Response from memory, in request order, never stalled
  typedef struct packed {
    logic                valid;
    logic [`PF_XLEN-1:0] rdata;
  } bus_rsp_t;

  // One fetched word tagged with the address it came from
  typedef struct packed {
    logic [`PF_XLEN-1:0] addr;
    logic [`PF_XLEN-1:0] data;
  } instr_t;

endpackage

/* fetch_request_ctrl.sv */
`timescale 1ns/1ns
`include "prefetch_cfg.svh"

module fetch_request_ctrl
  import prefetch_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  // Branch pulse from the core
  input  branch_t              branch_i,
  // High when the bus takes a request this cycle
  input  logic                 req_accept_i,
  // Response strobe from memory
  input  logic                 bus_rsp_valid_i,
  // Occupancy of the instruction buffer
  input  logic [`PF_CNT_W-1:0] buf_count_i,
  // Level, a new request may issue now
  output logic                 req_valid_o,
  // Push strobe for the current response
  output logic                 rsp_keep_o
);

  // Budget limit in the wider sum width
  localparam logic [`PF_CNT_W:0] DEPTH_LIMIT = (`PF_CNT_W+1)'(`PF_DEPTH);

  logic                 active_q;
  logic                 fetch_on;
  logic [`PF_CNT_W-1:0] outstanding_q;
  logic [`PF_CNT_W-1:0] outstanding_d;
  logic [`PF_CNT_W-1:0] discard_q;
  logic [`PF_CNT_W-1:0] discard_d;
  logic [`PF_CNT_W-1:0] buf_count_eff;
  logic [`PF_CNT_W:0]   budget_used;

  //////////////////////////////////////////////////
  // Request budget
  //////////////////////////////////////////////////

  // Fetching starts with the first branch, the pulse itself counts
  assign fetch_on = active_q || branch_i.taken;

  // Buffer flushes on a branch, so its words free up right away
  assign buf_count_eff = branch_i.taken ? '0 : buf_count_i;

  // One extra bit so the sum cannot wrap
  assign budget_used = {1'b0, outstanding_q} + {1'b0, buf_count_eff};

  assign req_valid_o = fetch_on && (budget_used < DEPTH_LIMIT);

  // Requests in flight, discards included
  always_comb
  begin
    outstanding_d = outstanding_q;
    if (req_accept_i && !bus_rsp_valid_i)
      outstanding_d = outstanding_q + 1'b1;
    else if (!req_accept_i && bus_rsp_valid_i)
      outstanding_d = outstanding_q - 1'b1;
  end

  //////////////////////////////////////////////////
  // Response filter
  //////////////////////////////////////////////////

  always_comb
  begin
    discard_d  = discard_q;
    rsp_keep_o = 1'b0;
    if (branch_i.taken)
    begin
      // Whatever is still in flight belongs to the old stream
      // A response in this very cycle is dropped here and not counted
      discard_d = outstanding_q - {{(`PF_CNT_W-1){1'b0}}, bus_rsp_valid_i};
    end
    else if (bus_rsp_valid_i)
    begin
      // Old responses drain first, in order
      if (discard_q != '0)
        discard_d = discard_q - 1'b1;
      else
        rsp_keep_o = 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // State registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      active_q      <= 1'b0;
      outstanding_q <= '0;
      discard_q     <= '0;
    end
    else
    begin
      // Stays set once the core has given a start address
      if (branch_i.taken)
        active_q <= 1'b1;
      outstanding_q <= outstanding_d;
      discard_q     <= discard_d;
    end
  end

endmodule

/* prefetcher.sv */
`timescale 1ns/1ns
`include "prefetch_cfg.svh"

module prefetcher
  import prefetch_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  // Branch pulse and target, target is word aligned
  input  branch_t  branch_i,
  // Budget from the request controller
  input  logic     req_valid_i,
  // Bus acceptance
  input  logic     bus_ready_i,
  // Request to the instruction bus
  output bus_req_t bus_req_o,
  // Request taken by the bus this cycle
  output logic     req_accept_o
);

  prefetch_state_e     state_q;
  prefetch_state_e     state_d;
  logic [`PF_XLEN-1:0] addr_q;
  logic [`PF_XLEN-1:0] addr_incr;
  logic [`PF_XLEN-1:0] addr_out;

  // Next sequential word, low bits forced to word alignment
  assign addr_incr = {addr_q[`PF_XLEN-1:2], 2'b00} + `PF_XLEN'(4);

  // Valid comes straight from the budget
  assign bus_req_o.valid = req_valid_i;
  assign bus_req_o.addr  = addr_out;

  assign req_accept_o = req_valid_i && bus_ready_i;

  //////////////////////////////////////////////////
  // Address steering FSM
  //////////////////////////////////////////////////

  always_comb
  begin
    state_d  = state_q;
    addr_out = addr_q;
    case (state_q)
      IDLE:
      begin
        // Branch target wins, else the word after the last one
        if (branch_i.taken)
          addr_out = branch_i.addr;
        else
          addr_out = addr_incr;
        // Target not taken yet, remember to offer it again
        if (branch_i.taken && !req_accept_o)
          state_d = BRANCH_WAIT;
      end

      BRANCH_WAIT:
      begin
        // Replay the held target, or a newer one if the core branches again
        if (branch_i.taken)
          addr_out = branch_i.addr;
        else
          addr_out = addr_q;
        // Target is on the bus, go back to sequential fetch
        if (req_accept_o)
          state_d = IDLE;
      end

      default:
      begin
        state_d = IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= IDLE;
      addr_q  <= '0;
    end
    else
    begin
      state_q <= state_d;
      // Holds the last issued or still pending address
      if (branch_i.taken || req_accept_o)
        addr_q <= addr_out;
    end
  end

endmodule

/* instr_buffer.sv */
`timescale 1ns/1ns
`include "prefetch_cfg.svh"

module instr_buffer
  import prefetch_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  // Branch pulse, flushes and reloads the address tag
  input  branch_t              branch_i,
  // Push strobe from the request controller
  input  logic                 rsp_keep_i,
  // Response data from memory
  input  logic [`PF_XLEN-1:0]  rsp_rdata_i,
  // Decoder side handshake
  input  logic                 instr_ready_i,
  output instr_t               instr_o,
  output logic                 instr_valid_o,
  // Occupancy back to the request controller
  output logic [`PF_CNT_W-1:0] buf_count_o
);

  localparam int PTR_W = $clog2(`PF_DEPTH);

  instr_t               mem [`PF_DEPTH];
  instr_t               wr_entry;
  logic [PTR_W-1:0]     wr_ptr_q;
  logic [PTR_W-1:0]     rd_ptr_q;
  logic [`PF_CNT_W-1:0] count_q;
  logic [`PF_XLEN-1:0]  pc_q;
  logic                 push;
  logic                 pop;

  // Wraps at PF_DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(`PF_DEPTH - 1))
      nxt = '0;
    else
      nxt = ptr + 1'b1;
    return nxt;
  endfunction

  //////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////

  // Nothing enters or leaves on a branch cycle
  assign push = rsp_keep_i && !branch_i.taken;
  assign pop  = instr_valid_o && instr_ready_i;

  // Old words are hidden from the decoder while the flush happens
  assign instr_valid_o = (count_q != '0) && !branch_i.taken;
  assign instr_o       = mem[rd_ptr_q];
  assign buf_count_o   = count_q;

  // Word gets the address the tag counter points at
  assign wr_entry.addr = pc_q;
  assign wr_entry.data = rsp_rdata_i;

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr_q] <= wr_entry;
  end

  // Pointers, count and address tag
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      pc_q     <= '0;
    end
    else if (branch_i.taken)
    begin
      // Empty in one cycle, next kept word is the target
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      pc_q     <= branch_i.addr;
    end
    else
    begin
      if (push)
      begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
        pc_q     <= pc_q + `PF_XLEN'(4);
      end
      if (pop)
        rd_ptr_q <= ptr_next(rd_ptr_q);
      // Simultaneous push and pop leave the count alone
      if (push && !pop)
        count_q <= count_q + 1'b1;
      else if (!push && pop)
        count_q <= count_q - 1'b1;
    end
  end

endmodule

/* fetch_unit_top.sv */
`timescale 1ns/1ns
`include "prefetch_cfg.svh"

module fetch_unit_top
  import prefetch_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  // Core side branch pulse with target
  input  branch_t  branch_i,
  // Instruction bus request channel
  output bus_req_t bus_req_o,
  input  logic     bus_ready_i,
  // Instruction bus response channel
  input  bus_rsp_t bus_rsp_i,
  // Decoder side
  output instr_t   instr_o,
  output logic     instr_valid_o,
  input  logic     instr_ready_i
);

  // Budget allows a new request
  logic                 req_valid;
  // Bus took the request
  logic                 req_accept;
  // Current response belongs to the live stream
  logic                 rsp_keep;
  // Words waiting for the decoder
  logic [`PF_CNT_W-1:0] buf_count;

  //////////////////////////////////////////////////
  // Request budget and response filter
  //////////////////////////////////////////////////

  fetch_request_ctrl u_req_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .branch_i        (branch_i),
    .req_accept_i    (req_accept),
    .bus_rsp_valid_i (bus_rsp_i.valid),
    .buf_count_i     (buf_count),
    .req_valid_o     (req_valid),
    .rsp_keep_o      (rsp_keep)
  );

  //////////////////////////////////////////////////
  // Address steering
  //////////////////////////////////////////////////

  prefetcher u_prefetcher (
    .clk          (clk),
    .rst_n        (rst_n),
    .branch_i     (branch_i),
    .req_valid_i  (req_valid),
    .bus_ready_i  (bus_ready_i),
    .bus_req_o    (bus_req_o),
    .req_accept_o (req_accept)
  );

  //////////////////////////////////////////////////
  // Word buffer towards the decoder
  //////////////////////////////////////////////////

  instr_buffer u_instr_buffer (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .rsp_keep_i    (rsp_keep),
    .rsp_rdata_i   (bus_rsp_i.rdata),
    .instr_ready_i (instr_ready_i),
    .instr_o       (instr_o),
    .instr_valid_o (instr_valid_o),
    .buf_count_o   (buf_count)
  );

endmodule

/* tb_fetch_unit.sv */
`timescale 1ns/1ns
`include "prefetch_cfg.svh"

module tb_fetch_unit
  import prefetch_pkg::*;
();

  // Memory returns address XOR this key
  localparam logic [`PF_XLEN-1:0] DATA_KEY = 32'hA5C3_0F96;
  // Length of each random phase
  localparam int RUN_CYCLES = 1450;

  logic     clk;
  logic     rst_n;
  branch_t  branch_i;
  bus_req_t bus_req_o;
  logic     bus_ready_i;
  bus_rsp_t bus_rsp_i;
  instr_t   instr_o;
  logic     instr_valid_o;
  logic     instr_ready_i;

  // Memory model queues hold accepted addresses and the cycle each response is due
  logic [`PF_XLEN-1:0] rsp_addr_q[$];
  int                  rsp_due_q[$];
  bus_rsp_t            rsp_next;

  // Reference model
  int                  cyc;
  logic                started;
  logic [`PF_XLEN-1:0] exp_req_addr;
  logic [`PF_XLEN-1:0] exp_instr_addr;
  int                  accept_count;
  int                  xfer_count;

  fetch_unit_top DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .bus_req_o     (bus_req_o),
    .bus_ready_i   (bus_ready_i),
    .bus_rsp_i     (bus_rsp_i),
    .instr_o       (instr_o),
    .instr_valid_o (instr_valid_o),
    .instr_ready_i (instr_ready_i)
  );

  always #5 clk = ~clk;

  //////////////////////////////////////////////////
  // Checking helpers
  //////////////////////////////////////////////////

  task automatic check_equal(
    input logic [`PF_XLEN-1:0] actual,
    input logic [`PF_XLEN-1:0] expected,
    input string               what
  );
    if (actual !== expected)
    begin
      $display("Mismatch at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string why);
    $display("Error at %0t ns: %s", $time, why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  //////////////////////////////////////////////////
  // Memory model and reference model
  //////////////////////////////////////////////////

  // At most one response per cycle and always in acceptance order
  always @(posedge clk)
  begin
    rsp_next = '0;
    if (rsp_addr_q.size() > 0 && rsp_due_q[0] <= cyc + 1)
    begin
      rsp_next.valid = 1'b1;
      rsp_next.rdata = rsp_addr_q[0] ^ DATA_KEY;
      void'(rsp_addr_q.pop_front());
      void'(rsp_due_q.pop_front());
    end
    bus_rsp_i <= rsp_next;
  end

  // Outputs are settled mid cycle and handshakes complete on the next edge
  always @(negedge clk)
  begin
    cyc = cyc + 1;
    if (branch_i.taken)
    begin
      started        = 1'b1;
      exp_req_addr   = branch_i.addr;
      exp_instr_addr = branch_i.addr;
    end
    // Front end stays quiet until the core gives a start address
    if (!started)
    begin
      check_equal(bus_req_o.valid, 1'b0, "request valid before the first branch");
      check_equal(instr_valid_o, 1'b0, "instruction valid before the first branch");
    end
    // Target or next sequential word stays on the bus while it stalls
    if (bus_req_o.valid)
      check_equal(bus_req_o.addr, exp_req_addr, "request address");
    if (bus_req_o.valid && bus_ready_i)
    begin
      rsp_addr_q.push_back(bus_req_o.addr);
      rsp_due_q.push_back(cyc + int'($urandom_range(5, 1)));
      exp_req_addr = exp_req_addr + 4;
      accept_count++;
    end
    // Accepted minus responded
    check_equal(rsp_addr_q.size() <= `PF_DEPTH, 1'b1, "requests in flight within budget");
    if (instr_valid_o && instr_ready_i)
    begin
      check_equal(instr_o.addr, exp_instr_addr, "instruction address");
      check_equal(instr_o.data, exp_instr_addr ^ DATA_KEY, "instruction data");
      exp_instr_addr = exp_instr_addr + 4;
      xfer_count++;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic drive_cycle(
    input logic                take,
    input logic [`PF_XLEN-1:0] target,
    input logic                bus_rdy,
    input logic                dec_rdy
  );
    branch_t br;
    br.taken = take;
    br.addr  = target;
    @(posedge clk);
    branch_i      <= br;
    bus_ready_i   <= bus_rdy;
    instr_ready_i <= dec_rdy;
  endtask

  function automatic logic [`PF_XLEN-1:0] random_target();
    return $urandom() & 32'hFFFF_FFFC;
  endfunction

  // Branch about every 30 cycles
  task automatic random_cycle();
    logic take;
    take = ($urandom_range(29, 0) == 0);
    drive_cycle(take, random_target(), $urandom_range(3, 0) != 0, $urandom_range(1, 0) == 1);
  endtask

  task automatic wait_for_transfers(input int goal, input int limit);
    int waited;
    waited = 0;
    while (xfer_count < goal && waited < limit)
    begin
      drive_cycle(1'b0, '0, 1'b1, $urandom_range(1, 0) == 1);
      waited++;
    end
    if (xfer_count < goal)
      abort_run("Timed out waiting for instruction words to reach the decoder");
  endtask

  task automatic wait_for_accept(input logic [`PF_XLEN-1:0] target, input int limit);
    int   waited;
    logic done;
    waited = 0;
    done   = 1'b0;
    while (!done && waited < limit)
    begin
      drive_cycle(1'b0, '0, 1'b1, $urandom_range(1, 0) == 1);
      @(negedge clk);
      if (bus_req_o.valid)
        check_equal(bus_req_o.addr, target, "branch target on the bus");
      done = bus_req_o.valid && bus_ready_i;
      waited++;
    end
    if (!done)
      abort_run("Timed out waiting for the bus to accept the branch target");
  endtask

  // Two branches while the bus refuses and the newest target must win
  task automatic branch_during_stall();
    logic [`PF_XLEN-1:0] first_target;
    logic [`PF_XLEN-1:0] second_target;
    first_target  = random_target();
    second_target = random_target();
    drive_cycle(1'b1, first_target, 1'b0, 1'b0);
    repeat (3)
    begin
      drive_cycle(1'b0, '0, 1'b0, 1'b0);
      @(negedge clk);
      check_equal(bus_req_o.valid, 1'b1, "request valid while the bus stalls");
      check_equal(bus_req_o.addr, first_target, "first target held on the bus");
    end
    drive_cycle(1'b1, second_target, 1'b0, 1'b0);
    repeat (3)
    begin
      drive_cycle(1'b0, '0, 1'b0, 1'b0);
      @(negedge clk);
      check_equal(bus_req_o.addr, second_target, "newest target held on the bus");
    end
    wait_for_accept(second_target, 20);
  endtask

  // Decoder refuses for 40 cycles so the buffer fills and requests stop
  task automatic decoder_stall();
    int accepts_before;
    int xfer_goal;
    drive_cycle(1'b1, random_target(), 1'b1, 1'b0);
    accepts_before = accept_count;
    repeat (40)
      drive_cycle(1'b0, '0, 1'b1, 1'b0);
    // Exactly one full budget of new words was requested
    check_equal(accept_count - accepts_before, `PF_DEPTH, "requests while the decoder stalls");
    xfer_goal = xfer_count + `PF_DEPTH;
    @(negedge clk);
    check_equal(bus_req_o.valid, 1'b0, "request stops with the buffer full");
    check_equal(instr_valid_o, 1'b1, "buffered word offered to the decoder");
    // All buffered words still come out in order
    wait_for_transfers(xfer_goal, 100);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial
  begin
    void'($urandom(36));
    clk            = 1'b0;
    rst_n          = 1'b0;
    branch_i       = '0;
    bus_ready_i    = 1'b0;
    bus_rsp_i      = '0;
    instr_ready_i  = 1'b0;
    cyc            = 0;
    started        = 1'b0;
    exp_req_addr   = '0;
    exp_instr_addr = '0;
    accept_count   = 0;
    xfer_count     = 0;

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    // Ready lines toggle but no branch yet
    repeat (20)
      drive_cycle(1'b0, '0, $urandom_range(1, 0) == 1, $urandom_range(1, 0) == 1);

    branch_during_stall();

    for (int i = 0; i < RUN_CYCLES; i++)
      random_cycle();

    decoder_stall();

    for (int i = 0; i < RUN_CYCLES; i++)
      random_cycle();

    // Sanity on overall progress
    check_equal(xfer_count > 200, 1'b1, "enough words delivered over the run");
    $display("Testbench passed");
    $finish;
  end

endmodule

/* project.f */
+incdir+.
prefetch_pkg.sv
fetch_request_ctrl.sv
prefetcher.sv
instr_buffer.sv
fetch_unit_top.sv
tb_fetch_unit.sv
